// ==== src/haar_geom_pkg.sv ====
`default_nettype none

package haar_geom_pkg;

	// detection window
	localparam int WIN_W = 10;
	localparam int WIN_H = 10;
	localparam int WIN_PIXELS = WIN_W * WIN_H;

	// pixel and integral image words, unsigned
	localparam int PIX_W = 8;
	localparam int II_W = 16;
	localparam int ADDR_W = 7;
	localparam int POS_W = 4;

	// signed feature value and stage sum
	localparam int FEAT_W = 32;
	localparam int SUM_W = 16;

endpackage

`default_nettype wire

// ==== src/cascade_db_pkg.sv ====
`default_nettype none

package cascade_db_pkg;

	localparam int DB_W = 12;
	localparam int REC_WORDS = 19;
	localparam int CLS_MAX = 18;
	localparam int CORNERS = 12;
	localparam int RECTS = 3;

	// classifier count and evaluator step counter widths
	localparam int CNT_W = 5;
	localparam int STEP_W = 4;

	// fetch 12 corners, one more for the last read, one to sum
	localparam int EVAL_LAST = CORNERS + 2;

	// meaning of each word slot inside a weak classifier record
	typedef enum logic [4:0] {
		F_A1, F_B1, F_C1, F_D1, F_W1,
		F_A2, F_B2, F_C2, F_D2, F_W2,
		F_A3, F_B3, F_C3, F_D3, F_W3,
		F_RSVD,
		F_NODE_THR,
		F_LEFT,
		F_RIGHT
	} rec_field_e;

	typedef enum logic [1:0] {
		EXPECT_COUNT,
		EXPECT_STAGE_THR,
		IN_RECORD
	} parse_state_e;

endpackage

`default_nettype wire

// ==== src/integral_image_builder.sv ====
`timescale 1ns/1ns
`default_nettype none

module integral_image_builder (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             pix_valid,
	input  logic [haar_geom_pkg::PIX_W-1:0]  pix,
	output logic                             ii_we,
	output logic [haar_geom_pkg::ADDR_W-1:0] ii_waddr,
	output logic [haar_geom_pkg::II_W-1:0]   ii_wdata,
	output logic                             image_ready
);
	import haar_geom_pkg::*;

	logic [POS_W-1:0] col;
	logic [POS_W-1:0] row;
	logic [II_W-1:0]  row_sum;
	logic [II_W-1:0]  row_sum_next;
	logic [II_W-1:0]  above;
	logic [II_W-1:0]  line_buf [WIN_W];
	logic             first_pix;
	logic             last_pix;

	assign first_pix = (row == '0) && (col == '0);
	assign last_pix = (row == POS_W'(WIN_H - 1)) && (col == POS_W'(WIN_W - 1));

	// running sum of the current row, restarted at column 0
	assign row_sum_next = (col == '0) ? II_W'(pix) : row_sum + II_W'(pix);
	assign above = (row == '0) ? '0 : line_buf[col];

	assign ii_we = pix_valid;
	assign ii_waddr = ADDR_W'(row * WIN_W + col);
	assign ii_wdata = above + row_sum_next;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			col <= '0;
			row <= '0;
			row_sum <= '0;
			image_ready <= 1'b0;
		end
		else if (pix_valid)
		begin
			row_sum <= row_sum_next;
			if (first_pix)
				image_ready <= 1'b0;
			if (last_pix)
			begin
				col <= '0;
				row <= '0;
				image_ready <= 1'b1;
			end
			else if (col == POS_W'(WIN_W - 1))
			begin
				col <= '0;
				row <= row + 1'b1;
			end
			else
				col <= col + 1'b1;
		end
	end

	// previous row of integral values, one entry per column
	always_ff @(posedge clk)
	begin
		if (pix_valid)
			line_buf[col] <= ii_wdata;
	end

	a_waddr_range: assert property (@(posedge clk) disable iff (!arst_n)
		ii_we |-> (ii_waddr < ADDR_W'(WIN_PIXELS)))
		else $error("integral image write address out of window");

endmodule

`default_nettype wire

// ==== src/integral_image_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module integral_image_ram (
	input  logic                             clk,
	input  logic                             ii_we,
	input  logic [haar_geom_pkg::ADDR_W-1:0] ii_waddr,
	input  logic [haar_geom_pkg::II_W-1:0]   ii_wdata,
	input  logic [haar_geom_pkg::ADDR_W-1:0] ii_raddr,
	output logic [haar_geom_pkg::II_W-1:0]   ii_rdata
);
	import haar_geom_pkg::*;

	logic [II_W-1:0] mem [WIN_PIXELS];

	always_ff @(posedge clk)
	begin
		if (ii_we)
			mem[ii_waddr] <= ii_wdata;
	end

	// registered read, corners past the window read as zero
	always_ff @(posedge clk)
	begin
		if (ii_raddr < ADDR_W'(WIN_PIXELS))
			ii_rdata <= mem[ii_raddr];
		else
			ii_rdata <= '0;
	end

endmodule

`default_nettype wire

// ==== src/stage_record_parser.sv ====
`timescale 1ns/1ns
`default_nettype none

module stage_record_parser (
	input  logic                                    clk,
	input  logic                                    arst_n,
	input  logic                                    db_valid,
	input  logic        [cascade_db_pkg::DB_W-1:0]  db_word,
	input  logic                                    image_ready,
	output logic                                    record_done,
	output logic        [haar_geom_pkg::ADDR_W-1:0] corner_idx [cascade_db_pkg::CORNERS],
	output logic signed [cascade_db_pkg::DB_W-1:0]  weight [cascade_db_pkg::RECTS],
	output logic signed [cascade_db_pkg::DB_W-1:0]  node_thr,
	output logic signed [cascade_db_pkg::DB_W-1:0]  left_vote,
	output logic signed [cascade_db_pkg::DB_W-1:0]  right_vote,
	output logic                                    stage_start,
	output logic        [cascade_db_pkg::CNT_W-1:0] cls_count,
	output logic signed [cascade_db_pkg::DB_W-1:0]  stage_thr
);
	import haar_geom_pkg::*;
	import cascade_db_pkg::*;

	parse_state_e     state;
	rec_field_e       slot;
	logic [CNT_W-1:0] rec_cnt;
	logic             last_slot;
	logic             last_rec;

	assign last_slot = (slot == rec_field_e'(REC_WORDS - 1));
	assign last_rec = (rec_cnt == cls_count - 1'b1);

	//////////////////////////////////////////////////
	// word sequencing
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= EXPECT_COUNT;
			slot <= F_A1;
			rec_cnt <= '0;
			cls_count <= '0;
			record_done <= 1'b0;
			stage_start <= 1'b0;
		end
		else
		begin
			record_done <= 1'b0;
			stage_start <= 1'b0;
			if (db_valid)
			begin
				case (state)
					EXPECT_COUNT:
					begin
						cls_count <= db_word[CNT_W-1:0];
						state <= EXPECT_STAGE_THR;
					end
					EXPECT_STAGE_THR:
					begin
						stage_start <= 1'b1;
						slot <= F_A1;
						rec_cnt <= '0;
						state <= IN_RECORD;
					end
					IN_RECORD:
					begin
						if (last_slot)
						begin
							record_done <= 1'b1;
							slot <= F_A1;
							rec_cnt <= rec_cnt + 1'b1;
							if (last_rec)
								state <= EXPECT_COUNT;
						end
						else
							slot <= rec_field_e'(slot + 1'b1);
					end
					default:
						state <= EXPECT_COUNT;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// field steering
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (db_valid && state == EXPECT_STAGE_THR)
			stage_thr <= db_word;
		if (db_valid && state == IN_RECORD)
		begin
			case (slot)
				F_A1: corner_idx[0] <= db_word[ADDR_W-1:0];
				F_B1: corner_idx[1] <= db_word[ADDR_W-1:0];
				F_C1: corner_idx[2] <= db_word[ADDR_W-1:0];
				F_D1: corner_idx[3] <= db_word[ADDR_W-1:0];
				F_W1: weight[0] <= db_word;
				F_A2: corner_idx[4] <= db_word[ADDR_W-1:0];
				F_B2: corner_idx[5] <= db_word[ADDR_W-1:0];
				F_C2: corner_idx[6] <= db_word[ADDR_W-1:0];
				F_D2: corner_idx[7] <= db_word[ADDR_W-1:0];
				F_W2: weight[1] <= db_word;
				F_A3: corner_idx[8] <= db_word[ADDR_W-1:0];
				F_B3: corner_idx[9] <= db_word[ADDR_W-1:0];
				F_C3: corner_idx[10] <= db_word[ADDR_W-1:0];
				F_D3: corner_idx[11] <= db_word[ADDR_W-1:0];
				F_W3: weight[2] <= db_word;
				F_NODE_THR: node_thr <= db_word;
				F_LEFT: left_vote <= db_word;
				F_RIGHT: right_vote <= db_word;
				// slot 15 carries nothing for this stage
				F_RSVD: ;
				default: ;
			endcase
		end
	end

	a_db_after_image: assert property (@(posedge clk) disable iff (!arst_n)
		db_valid |-> image_ready)
		else $error("database word arrived before the image was ready");

	a_count_range: assert property (@(posedge clk) disable iff (!arst_n)
		(db_valid && state == EXPECT_COUNT) |-> (db_word >= 1 && db_word <= CLS_MAX))
		else $error("classifier count word out of range");

endmodule

`default_nettype wire

// ==== src/haar_feature_eval.sv ====
`timescale 1ns/1ns
`default_nettype none

module haar_feature_eval (
	input  logic                                    clk,
	input  logic                                    arst_n,
	input  logic                                    record_done,
	input  logic        [haar_geom_pkg::ADDR_W-1:0] corner_idx [cascade_db_pkg::CORNERS],
	input  logic signed [cascade_db_pkg::DB_W-1:0]  weight [cascade_db_pkg::RECTS],
	input  logic signed [cascade_db_pkg::DB_W-1:0]  node_thr,
	input  logic signed [cascade_db_pkg::DB_W-1:0]  left_vote,
	input  logic signed [cascade_db_pkg::DB_W-1:0]  right_vote,
	input  logic        [haar_geom_pkg::II_W-1:0]   ii_rdata,
	output logic        [haar_geom_pkg::ADDR_W-1:0] ii_raddr,
	output logic                                    vote_valid,
	output logic signed [cascade_db_pkg::DB_W-1:0]  vote
);
	import haar_geom_pkg::*;
	import cascade_db_pkg::*;

	// step 0 is idle, steps 1 to EVAL_LAST follow record_done
	logic        [STEP_W-1:0] step;
	logic        [STEP_W-1:0] fetch_sel;
	logic        [STEP_W-1:0] store_sel;
	logic        [ADDR_W-1:0] idx_q [CORNERS];
	logic signed [DB_W-1:0]   weight_q [RECTS];
	logic signed [DB_W-1:0]   node_thr_q;
	logic signed [DB_W-1:0]   left_q;
	logic signed [DB_W-1:0]   right_q;
	logic        [II_W-1:0]   corner_val [CORNERS];
	logic signed [FEAT_W-1:0] rect_diff [RECTS];
	logic signed [FEAT_W-1:0] rect_term [RECTS];
	logic signed [FEAT_W-1:0] feature;
	logic                     fetching;
	logic                     storing;

	assign fetch_sel = step - 1'b1;
	assign store_sel = step - 2'd2;
	assign fetching = (step != '0) && (step <= STEP_W'(CORNERS));
	assign storing = (step >= 2'd2) && (step <= STEP_W'(CORNERS + 1));

	// one corner read per step, data comes back a step later
	assign ii_raddr = fetching ? idx_q[fetch_sel] : '0;

	//////////////////////////////////////////////////
	// weighted rectangle sums
	//////////////////////////////////////////////////

	always_comb
	begin
		feature = '0;
		for (int r = 0; r < RECTS; r++)
		begin
			rect_diff[r] = FEAT_W'(corner_val[4*r]) + FEAT_W'(corner_val[4*r+3])
				- FEAT_W'(corner_val[4*r+1]) - FEAT_W'(corner_val[4*r+2]);
			rect_term[r] = rect_diff[r] * FEAT_W'(weight_q[r]);
			feature = feature + rect_term[r];
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			step <= '0;
			vote_valid <= 1'b0;
		end
		else
		begin
			vote_valid <= 1'b0;
			if (record_done)
				step <= STEP_W'(1);
			else if (step == STEP_W'(EVAL_LAST))
			begin
				step <= '0;
				vote_valid <= 1'b1;
			end
			else if (step != '0)
				step <= step + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (record_done)
		begin
			for (int c = 0; c < CORNERS; c++)
				idx_q[c] <= corner_idx[c];
			for (int r = 0; r < RECTS; r++)
				weight_q[r] <= weight[r];
			node_thr_q <= node_thr;
			left_q <= left_vote;
			right_q <= right_vote;
		end
		if (storing)
			corner_val[store_sel] <= ii_rdata;
		if (step == STEP_W'(EVAL_LAST))
			vote <= (feature > FEAT_W'(node_thr_q)) ? right_q : left_q;
	end

	a_single_record: assert property (@(posedge clk) disable iff (!arst_n)
		record_done |-> (step == '0))
		else $error("record arrived while the evaluator was busy");

endmodule

`default_nettype wire

// ==== src/stage_decision.sv ====
`timescale 1ns/1ns
`default_nettype none

module stage_decision (
	input  logic                                    clk,
	input  logic                                    arst_n,
	input  logic                                    stage_start,
	input  logic        [cascade_db_pkg::CNT_W-1:0] cls_count,
	input  logic signed [cascade_db_pkg::DB_W-1:0]  stage_thr,
	input  logic                                    vote_valid,
	input  logic signed [cascade_db_pkg::DB_W-1:0]  vote,
	output logic                                    decision_valid,
	output logic                                    candidate
);
	import haar_geom_pkg::*;
	import cascade_db_pkg::*;

	logic signed [SUM_W-1:0] sum_q;
	logic signed [SUM_W-1:0] sum_next;
	logic        [CNT_W-1:0] vote_cnt;
	logic        [CNT_W-1:0] n_q;
	logic signed [DB_W-1:0]  thr_q;
	logic                    armed;

	assign sum_next = sum_q + SUM_W'(vote);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sum_q <= '0;
			vote_cnt <= '0;
			n_q <= '0;
			armed <= 1'b0;
			decision_valid <= 1'b0;
			candidate <= 1'b0;
		end
		else
		begin
			decision_valid <= 1'b0;
			if (stage_start)
			begin
				sum_q <= '0;
				vote_cnt <= '0;
				n_q <= cls_count;
				armed <= 1'b1;
			end
			else if (vote_valid)
			begin
				sum_q <= sum_next;
				vote_cnt <= vote_cnt + 1'b1;
				// last vote of the stage closes it
				if (vote_cnt + 1'b1 == n_q)
				begin
					decision_valid <= 1'b1;
					candidate <= (sum_next > SUM_W'(thr_q));
					armed <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (stage_start)
			thr_q <= stage_thr;
	end

	a_vote_in_stage: assert property (@(posedge clk) disable iff (!arst_n)
		vote_valid |-> armed)
		else $error("vote arrived outside a stage");

	a_stage_closed: assert property (@(posedge clk) disable iff (!arst_n)
		stage_start |-> !armed)
		else $error("new stage started before the previous decision");

endmodule

`default_nettype wire

// ==== src/haar_cascade_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module haar_cascade_top (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             pix_valid,
	input  logic [haar_geom_pkg::PIX_W-1:0]  pix,
	input  logic                             db_valid,
	input  logic [cascade_db_pkg::DB_W-1:0]  db_word,
	output logic                             image_ready,
	output logic                             decision_valid,
	output logic                             candidate
);
	import haar_geom_pkg::*;
	import cascade_db_pkg::*;

	logic                     ii_we;
	logic        [ADDR_W-1:0] ii_waddr;
	logic        [II_W-1:0]   ii_wdata;
	logic        [ADDR_W-1:0] ii_raddr;
	logic        [II_W-1:0]   ii_rdata;
	logic                     record_done;
	logic        [ADDR_W-1:0] corner_idx [CORNERS];
	logic signed [DB_W-1:0]   weight [RECTS];
	logic signed [DB_W-1:0]   node_thr;
	logic signed [DB_W-1:0]   left_vote;
	logic signed [DB_W-1:0]   right_vote;
	logic                     stage_start;
	logic        [CNT_W-1:0]  cls_count;
	logic signed [DB_W-1:0]   stage_thr;
	logic                     vote_valid;
	logic signed [DB_W-1:0]   vote;

	//////////////////////////////////////////////////
	// image path
	//////////////////////////////////////////////////

	integral_image_builder u_integral_image_builder (
		.clk         (clk),
		.arst_n      (arst_n),
		.pix_valid   (pix_valid),
		.pix         (pix),
		.ii_we       (ii_we),
		.ii_waddr    (ii_waddr),
		.ii_wdata    (ii_wdata),
		.image_ready (image_ready)
	);

	integral_image_ram u_integral_image_ram (
		.clk      (clk),
		.ii_we    (ii_we),
		.ii_waddr (ii_waddr),
		.ii_wdata (ii_wdata),
		.ii_raddr (ii_raddr),
		.ii_rdata (ii_rdata)
	);

	//////////////////////////////////////////////////
	// classifier path
	//////////////////////////////////////////////////

	stage_record_parser u_stage_record_parser (
		.clk         (clk),
		.arst_n      (arst_n),
		.db_valid    (db_valid),
		.db_word     (db_word),
		.image_ready (image_ready),
		.record_done (record_done),
		.corner_idx  (corner_idx),
		.weight      (weight),
		.node_thr    (node_thr),
		.left_vote   (left_vote),
		.right_vote  (right_vote),
		.stage_start (stage_start),
		.cls_count   (cls_count),
		.stage_thr   (stage_thr)
	);

	haar_feature_eval u_haar_feature_eval (
		.clk         (clk),
		.arst_n      (arst_n),
		.record_done (record_done),
		.corner_idx  (corner_idx),
		.weight      (weight),
		.node_thr    (node_thr),
		.left_vote   (left_vote),
		.right_vote  (right_vote),
		.ii_rdata    (ii_rdata),
		.ii_raddr    (ii_raddr),
		.vote_valid  (vote_valid),
		.vote        (vote)
	);

	stage_decision u_stage_decision (
		.clk            (clk),
		.arst_n         (arst_n),
		.stage_start    (stage_start),
		.cls_count      (cls_count),
		.stage_thr      (stage_thr),
		.vote_valid     (vote_valid),
		.vote           (vote),
		.decision_valid (decision_valid),
		.candidate      (candidate)
	);

endmodule

`default_nettype wire

// ==== test/tb_haar_model.svh ====
`ifndef TB_HAAR_MODEL_SVH
`define TB_HAAR_MODEL_SVH

// record layout: four corners and a weight per rectangle, then the tail slots
localparam int SLOTS_PER_RECT = 5;
localparam int RSVD_SLOT = 15;
localparam int NODE_SLOT = 16;
localparam int LEFT_SLOT = 17;
localparam int RIGHT_SLOT = 18;

// 32 bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	logic fb;
	fb = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], fb};
endfunction

function automatic logic [31:0] take_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
	begin
		lfsr_state = lfsr_next(lfsr_state);
		v = {v[30:0], lfsr_state[0]};
	end
	return v;
endfunction

function automatic int as_signed(input logic [DB_W-1:0] w);
	return int'($signed(w));
endfunction

// each entry is the sum of all pixels above and left of it, itself included
function automatic void build_integral();
	int acc;
	for (int r = 0; r < WIN_H; r++)
		for (int c = 0; c < WIN_W; c++)
		begin
			acc = 0;
			for (int y = 0; y <= r; y++)
				for (int x = 0; x <= c; x++)
					acc += int'(pix_ref[y * WIN_W + x]);
			ii_ref[r * WIN_W + c] = II_W'(acc);
		end
endfunction

// indices past the window read as zero
function automatic int corner_value(input logic [DB_W-1:0] w);
	int idx;
	idx = int'(w[ADDR_W-1:0]);
	return (idx < WIN_PIXELS) ? int'(ii_ref[idx]) : 0;
endfunction

function automatic int feature_value(input int k);
	int f;
	int diff;
	int base;
	f = 0;
	for (int r = 0; r < RECTS; r++)
	begin
		base = SLOTS_PER_RECT * r;
		diff = corner_value(rec_word[k][base]) + corner_value(rec_word[k][base + 3])
			- corner_value(rec_word[k][base + 1]) - corner_value(rec_word[k][base + 2]);
		f += diff * as_signed(rec_word[k][base + 4]);
	end
	return f;
endfunction

function automatic int vote_of(input int k);
	if (feature_value(k) > as_signed(rec_word[k][NODE_SLOT]))
		return as_signed(rec_word[k][RIGHT_SLOT]);
	return as_signed(rec_word[k][LEFT_SLOT]);
endfunction

// stage sum wraps at SUM_W bits
function automatic int stage_sum(input int n);
	logic signed [SUM_W-1:0] sum;
	sum = '0;
	for (int k = 0; k < n; k++)
		sum = sum + SUM_W'(vote_of(k));
	return int'(sum);
endfunction

`endif

// ==== test/tb_haar_cascade.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_haar_cascade;
	import haar_geom_pkg::*;
	import cascade_db_pkg::*;

	localparam int NUM_FRAMES = 3;
	localparam int NUM_STAGES = 7;
	localparam int TOTAL_CLS = 1 + 2 * CLS_MAX + 4 + 4 + 2;
	localparam int DECISION_LAT = 17;
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * WIN_PIXELS
		+ NUM_STAGES * (2 + DECISION_LAT) + TOTAL_CLS * REC_WORDS + 400;

	logic              clk;
	logic              arst_n;
	logic              pix_valid;
	logic [PIX_W-1:0]  pix;
	logic              db_valid;
	logic [DB_W-1:0]   db_word;
	logic              image_ready;
	logic              decision_valid;
	logic              candidate;

	// markers that travel with the stimulus
	logic              frame_first;
	logic              frame_last;
	logic              last_word;
	logic              exp_candidate;

	logic [31:0]       lfsr_state;
	logic [PIX_W-1:0]  pix_ref [WIN_PIXELS];
	logic [II_W-1:0]   ii_ref [WIN_PIXELS];
	logic [DB_W-1:0]   rec_word [CLS_MAX][REC_WORDS];
	int                value_errors;
	int                timing_errors;
	int                other_errors;
	int                decisions;
	int                cycles;

	`include "tb_haar_model.svh"

	haar_cascade_top u_haar_cascade_top (
		.clk            (clk),
		.arst_n         (arst_n),
		.pix_valid      (pix_valid),
		.pix            (pix),
		.db_valid       (db_valid),
		.db_word        (db_word),
		.image_ready    (image_ready),
		.decision_valid (decision_valid),
		.candidate      (candidate)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (arst_n && decision_valid)
			decisions <= decisions + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	a_reset_quiet: assert property (@(posedge clk)
		(!arst_n && cycles > 0) |-> (!image_ready && !decision_valid && !candidate))
		else
		begin
			value_errors++;
			$display("MISMATCH {image_ready,decision_valid,candidate}: got %h expected %h",
				$sampled({image_ready, decision_valid, candidate}), 3'h0);
		end

	a_ready_rise: assert property (@(posedge clk) disable iff (!arst_n)
		(pix_valid && frame_last) |=> image_ready)
		else
		begin
			value_errors++;
			$display("MISMATCH image_ready: got %h expected %h", $sampled(image_ready), 1'b1);
		end

	a_ready_fall: assert property (@(posedge clk) disable iff (!arst_n)
		(pix_valid && frame_first) |=> !image_ready)
		else
		begin
			value_errors++;
			$display("MISMATCH image_ready: got %h expected %h", $sampled(image_ready), 1'b0);
		end

	a_ready_cause: assert property (@(posedge clk) disable iff (!arst_n)
		(image_ready != $past(image_ready)) |-> $past(pix_valid && (frame_first || frame_last)))
		else
		begin
			timing_errors++;
			$display("image_ready changed without a first or last pixel");
		end

	a_decision_time: assert property (@(posedge clk) disable iff (!arst_n)
		decision_valid |-> $past(db_valid && last_word, DECISION_LAT))
		else
		begin
			timing_errors++;
			$display("decision_valid came at the wrong distance from the last word");
		end

	a_decision_due: assert property (@(posedge clk) disable iff (!arst_n)
		$past(db_valid && last_word, DECISION_LAT) |-> decision_valid)
		else
		begin
			timing_errors++;
			$display("decision_valid missing %0d cycles after the last word", DECISION_LAT);
		end

	a_candidate_value: assert property (@(posedge clk) disable iff (!arst_n)
		decision_valid |-> (candidate == exp_candidate))
		else
		begin
			value_errors++;
			$display("MISMATCH candidate: got %h expected %h", $sampled(candidate), exp_candidate);
		end

	a_candidate_hold: assert property (@(posedge clk) disable iff (!arst_n)
		!decision_valid |-> $stable(candidate))
		else
		begin
			timing_errors++;
			$display("candidate changed without a decision");
		end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	task automatic send_frame();
		for (int i = 0; i < WIN_PIXELS; i++)
			pix_ref[i] = PIX_W'(take_bits(PIX_W));
		build_integral();
		for (int i = 0; i < WIN_PIXELS; i++)
		begin
			@(posedge clk);
			#2;
			pix_valid = 1'b1;
			pix = pix_ref[i];
			frame_first = (i == 0);
			frame_last = (i == WIN_PIXELS - 1);
		end
		@(posedge clk);
		#2;
		pix_valid = 1'b0;
		frame_first = 1'b0;
		frame_last = 1'b0;
		while (!image_ready)
			idle_cycles(1);
	endtask

	function automatic void fill_stage(input int n);
		for (int k = 0; k < n; k++)
			for (int s = 0; s < REC_WORDS; s++)
				rec_word[k][s] = DB_W'(take_bits(DB_W));
	endfunction

	// votes kept to 11 bits so that sum minus one still fits a threshold word
	function automatic void narrow_votes(input int k);
		rec_word[k][LEFT_SLOT] = {rec_word[k][LEFT_SLOT][10], rec_word[k][LEFT_SLOT][10:0]};
		rec_word[k][RIGHT_SLOT] = {rec_word[k][RIGHT_SLOT][10], rec_word[k][RIGHT_SLOT][10:0]};
	endfunction

	task automatic drive_word(input logic [DB_W-1:0] w, input logic last);
		@(posedge clk);
		#2;
		db_valid = 1'b1;
		db_word = w;
		last_word = last;
	endtask

	task automatic run_stage(input int n, input logic [DB_W-1:0] thr);
		exp_candidate = (stage_sum(n) > as_signed(thr));
		drive_word(DB_W'(n), 1'b0);
		drive_word(thr, 1'b0);
		for (int k = 0; k < n; k++)
			for (int s = 0; s < REC_WORDS; s++)
				drive_word(rec_word[k][s], (k == n - 1) && (s == REC_WORDS - 1));
		@(posedge clk);
		#2;
		db_valid = 1'b0;
		last_word = 1'b0;
		while (!decision_valid)
			idle_cycles(1);
		idle_cycles(3);
	endtask

	initial
	begin
		logic [DB_W-1:0] thr;
		int              model_sum;

		clk = 1'b0;
		arst_n = 1'b0;
		pix_valid = 1'b0;
		pix = '0;
		db_valid = 1'b0;
		db_word = '0;
		frame_first = 1'b0;
		frame_last = 1'b0;
		last_word = 1'b0;
		exp_candidate = 1'b0;
		lfsr_state = 32'h5e62_c8a6;
		value_errors = 0;
		timing_errors = 0;
		other_errors = 0;
		decisions = 0;
		cycles = 0;

		repeat (16) @(posedge clk);
		#2;
		arst_n = 1'b1;
		idle_cycles(2);

		send_frame();
		fill_stage(1);
		run_stage(1, DB_W'(take_bits(DB_W)));

		// full stage and then the same stage with new reserved words
		fill_stage(CLS_MAX);
		thr = DB_W'(take_bits(DB_W));
		run_stage(CLS_MAX, thr);
		for (int k = 0; k < CLS_MAX; k++)
			rec_word[k][RSVD_SLOT] = DB_W'(take_bits(DB_W));
		run_stage(CLS_MAX, thr);

		send_frame();
		fill_stage(4);
		run_stage(4, DB_W'(take_bits(DB_W)));
		send_frame();
		fill_stage(4);
		run_stage(4, DB_W'(take_bits(DB_W)));

		// threshold one below the sum and then equal to it
		fill_stage(1);
		narrow_votes(0);
		model_sum = stage_sum(1);
		run_stage(1, DB_W'(model_sum - 1));
		a_flip_high: assert (candidate == 1'b1)
		else
		begin
			value_errors++;
			$display("MISMATCH candidate: got %h expected %h", candidate, 1'b1);
		end
		run_stage(1, DB_W'(model_sum));
		a_flip_low: assert (candidate == 1'b0)
		else
		begin
			value_errors++;
			$display("MISMATCH candidate: got %h expected %h", candidate, 1'b0);
		end

		idle_cycles(4);
		if (decisions != NUM_STAGES)
		begin
			other_errors++;
			$display("expected %0d decisions but saw %0d", NUM_STAGES, decisions);
		end
		$display("errors: value %0d, timing %0d, other %0d", value_errors, timing_errors,
			other_errors);
		if (value_errors + timing_errors + other_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+test
src/haar_geom_pkg.sv
src/cascade_db_pkg.sv
src/integral_image_builder.sv
src/integral_image_ram.sv
src/stage_record_parser.sv
src/haar_feature_eval.sv
src/stage_decision.sv
src/haar_cascade_top.sv
test/tb_haar_cascade.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_haar_cascade
LINT_TOP   := haar_cascade_top
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
PASS_TEXT  := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
